/* Makefile */
VERILATOR  ?= verilator
VFLAGS     = --binary --timing
LINTFLAGS  = --lint-only --timing
TOP        = tbDataMemory
RTL_TOP    = dataMemory
FILELIST   = filelist.f
OBJ_DIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* backingRam.sv */
`timescale 1ns/10ps
`default_nettype none

module backingRam (
    input  logic                          clk,
    memReqIf.ram                          req,
    output logic [memPkg::dataWidth-1:0]  rdata   // word addressed on the previous edge
);

    logic [memPkg::dataWidth-1:0] mem [memPkg::ramDepth];
    logic [memPkg::tagWidth+memPkg::setWidth-1:0] wordIdx;

    assign wordIdx = {req.tag, req.set};

    // every store lands here, enabled lanes only
    always_ff @(posedge clk) begin
        for (int i = 0; i < memPkg::dataWidth/8; i++) begin
            if (req.byteEn[i]) begin
                mem[wordIdx][8*i +: 8] <= req.wdata[8*i +: 8];
            end
        end
        rdata <= mem[wordIdx];  // old data on a same-cycle store
    end

endmodule

`default_nettype wire

/* dataCache.sv */
`timescale 1ns/10ps
`default_nettype none

module dataCache (
    input  logic                          clk,
    input  logic                          rstN,
    memReqIf.cache                        req,
    input  logic [memPkg::dataWidth-1:0]  ramData,   // refill source
    memRspIf.cache                        rsp
);

    // one word per line, direct mapped
    logic [2**memPkg::setWidth-1:0] validArr;
    logic [memPkg::tagWidth-1:0]    tagArr  [2**memPkg::setWidth];
    logic [memPkg::dataWidth-1:0]   lineArr [2**memPkg::setWidth];

    // refill of the set that missed on the previous load
    logic                           refillPend;
    logic [memPkg::setWidth-1:0]    refillSet;

    logic                           isLoad;
    logic                           lookupHit;
    logic                           missAlloc;
    logic                           pendSame;
    logic                           lineWrite;
    logic [memPkg::dataWidth-1:0]   mergeBase;
    logic [memPkg::dataWidth-1:0]   mergedLine;

    always_comb begin
        isLoad    = (req.kind == memPkg::loadWord) || (req.kind == memPkg::loadByte);
        lookupHit = validArr[req.set] && (tagArr[req.set] == req.tag);
        missAlloc = isLoad && !lookupHit;
        pendSame  = refillPend && (refillSet == req.set);
        // word store always allocates, byte store only on hit
        lineWrite = (req.kind == memPkg::storeWord) ||
                    ((req.kind == memPkg::storeByte) && lookupHit);
    end

    // line not filled yet when the refill is still pending,
    // so a byte merge starts from the RAM word instead
    always_comb begin
        mergeBase = pendSame ? ramData : lineArr[req.set];
        for (int i = 0; i < memPkg::dataWidth/8; i++) begin
            mergedLine[8*i +: 8] = req.byteEn[i] ? req.wdata[8*i +: 8] : mergeBase[8*i +: 8];
        end
    end

    // control state
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validArr   <= '0;
            refillPend <= 1'b0;
            refillSet  <= '0;
            rsp.valid  <= 1'b0;
            rsp.hit    <= 1'b0;
            rsp.useRam <= 1'b0;
        end else begin
            rsp.valid  <= isLoad;
            rsp.hit    <= isLoad && lookupHit;
            // forward RAM data on a miss or on a hit to a line still filling
            rsp.useRam <= isLoad && (!lookupHit || pendSame);
            refillPend <= missAlloc;
            if (missAlloc) begin
                refillSet <= req.set;
            end
            if (lineWrite || missAlloc) begin
                validArr[req.set] <= 1'b1;
            end
        end
    end

    // tag and line arrays, response payload
    always_ff @(posedge clk) begin
        // refill lands one edge after the miss unless a store to the set overrides it
        if (refillPend && !(lineWrite && (req.set == refillSet))) begin
            lineArr[refillSet] <= ramData;
        end
        if (lineWrite) begin
            lineArr[req.set] <= mergedLine;  // write-through copy
        end
        if (lineWrite || missAlloc) begin
            tagArr[req.set] <= req.tag;  // tag set at once on a miss
        end
        rsp.lineData <= lineArr[req.set];
        rsp.byteLoad <= (req.kind == memPkg::loadByte);
        rsp.lane     <= req.lane;
    end

endmodule

`default_nettype wire

/* dataMemory.sv */
`timescale 1ns/10ps
`default_nettype none

module dataMemory (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          we,
    input  logic                          re,
    input  logic                          stSrc,
    input  logic                          ldSrc,
    input  logic [memPkg::addrWidth-1:0]  a,
    input  logic [memPkg::dataWidth-1:0]  wd,
    output logic [memPkg::dataWidth-1:0]  rd,
    output logic                          rdValid,
    output logic                          hit
);

    memReqIf reqBus ();
    memRspIf rspBus ();

    logic [memPkg::dataWidth-1:0] ramData;  // RAM read word, refill and miss data

    lsuIssue uIssue (
        .we    (we),
        .re    (re),
        .stSrc (stSrc),
        .ldSrc (ldSrc),
        .a     (a),
        .wd    (wd),
        .req   (reqBus.issue)
    );

    dataCache uCache (
        .clk     (clk),
        .rstN    (rstN),
        .req     (reqBus.cache),
        .ramData (ramData),
        .rsp     (rspBus.cache)
    );

    backingRam uRam (
        .clk   (clk),
        .req   (reqBus.ram),
        .rdata (ramData)
    );

    loadAlign uAlign (
        .rsp     (rspBus.align),
        .ramData (ramData),
        .rd      (rd),
        .rdValid (rdValid),
        .hit     (hit)
    );

endmodule

`default_nettype wire

/* filelist.f */
memPkg.sv
memReqIf.sv
memRspIf.sv
lsuIssue.sv
dataCache.sv
backingRam.sv
loadAlign.sv
dataMemory.sv
tbClock.sv
tbDataMemory.sv

/* loadAlign.sv */
`timescale 1ns/10ps
`default_nettype none

module loadAlign (
    memRspIf.align                        rsp,
    input  logic [memPkg::dataWidth-1:0]  ramData,
    output logic [memPkg::dataWidth-1:0]  rd,
    output logic                          rdValid,
    output logic                          hit
);

    logic [memPkg::dataWidth-1:0] word;

    always_comb begin
        // RAM word on a miss or while the line refills
        word = rsp.useRam ? ramData : rsp.lineData;
        if (rsp.byteLoad) begin
            rd = {{(memPkg::dataWidth-8){1'b0}}, word[8*rsp.lane +: 8]};  // zero extend
        end else begin
            rd = word;
        end
    end

    assign rdValid = rsp.valid;
    assign hit     = rsp.hit;

endmodule

`default_nettype wire

/* lsuIssue.sv */
`timescale 1ns/10ps
`default_nettype none

module lsuIssue (
    input  logic                          we,
    input  logic                          re,
    input  logic                          stSrc,
    input  logic                          ldSrc,
    input  logic [memPkg::addrWidth-1:0]  a,
    input  logic [memPkg::dataWidth-1:0]  wd,
    memReqIf.issue                        req
);

    // strobe decode, store wins over a read in the same cycle
    always_comb begin
        if (we) begin
            req.kind = stSrc ? memPkg::storeByte : memPkg::storeWord;
        end else if (re) begin
            req.kind = ldSrc ? memPkg::loadByte : memPkg::loadWord;
        end else begin
            req.kind = memPkg::idle;
        end
    end

    // address split
    assign req.lane = a[memPkg::laneWidth-1:0];
    assign req.set  = a[memPkg::laneWidth +: memPkg::setWidth];
    assign req.tag  = a[memPkg::addrWidth-1 -: memPkg::tagWidth];

    // store data and lane enables
    always_comb begin
        case (req.kind)
            memPkg::storeWord: begin
                req.wdata  = wd;
                req.byteEn = '1;
            end
            memPkg::storeByte: begin
                req.wdata  = {(memPkg::dataWidth/8){wd[7:0]}};  // low byte in every lane
                req.byteEn = 4'b0001 << a[memPkg::laneWidth-1:0];
            end
            default: begin
                req.wdata  = wd;  // don't care for loads
                req.byteEn = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* memPkg.sv */
`default_nettype none

package memPkg;

    // data path and address sizes
    localparam int dataWidth = 32;
    localparam int addrWidth = 10;   // 1 KiB byte address
    localparam int laneWidth = 2;    // byte within word
    localparam int setWidth  = 3;    // 8 sets, one word per line
    localparam int tagWidth  = addrWidth - setWidth - laneWidth;
    localparam int ramDepth  = 256;  // words

    // address split, low to high: lane, set, tag
    // the RAM word index is {tag, set}

    // one decoded access per cycle
    typedef enum logic [2:0] {
        idle,
        loadWord,
        loadByte,   // zero-extended
        storeWord,  // allocates the line
        storeByte   // no allocate on miss
    } accessKind;

endpackage

`default_nettype wire

/* memReqIf.sv */
`timescale 1ns/10ps
`default_nettype none

// decoded access, issue stage to cache and RAM
interface memReqIf;

    memPkg::accessKind                 kind;
    logic [memPkg::setWidth-1:0]       set;
    logic [memPkg::tagWidth-1:0]       tag;
    logic [memPkg::laneWidth-1:0]      lane;
    logic [memPkg::dataWidth-1:0]      wdata;   // store byte already in its lane
    logic [memPkg::dataWidth/8-1:0]    byteEn;  // zero for loads

    modport issue (
        output kind,
        output set,
        output tag,
        output lane,
        output wdata,
        output byteEn
    );

    modport cache (
        input kind,
        input set,
        input tag,
        input lane,
        input wdata,
        input byteEn
    );

    // RAM only needs the word index and the store lanes
    modport ram (
        input set,
        input tag,
        input wdata,
        input byteEn
    );

endinterface

`default_nettype wire

/* memRspIf.sv */
`timescale 1ns/10ps
`default_nettype none

// registered lookup result, cache to load aligner
interface memRspIf;

    logic                             valid;     // load issued last cycle
    logic                             hit;
    logic [memPkg::dataWidth-1:0]     lineData;
    logic                             byteLoad;
    logic [memPkg::laneWidth-1:0]     lane;
    logic                             useRam;    // miss or refill forward

    modport cache (
        output valid,
        output hit,
        output lineData,
        output byteLoad,
        output lane,
        output useRam
    );

    modport align (
        input valid,
        input hit,
        input lineData,
        input byteLoad,
        input lane,
        input useRam
    );

endinterface

`default_nettype wire

/* tbClock.sv */
`timescale 1ns/10ps
`default_nettype none

// free running clock and power-on reset for the testbench
module tbClock (
    output logic clk,
    output logic rstN
);

    localparam int halfPeriod  = 2;   // 4 ns clock
    localparam int resetCycles = 16;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // release just after an edge so no flop sees it change at the edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

/* tbDataMemory.sv */
`timescale 1ns/10ps
`default_nettype none

module tbDataMemory;

    localparam int resetCycles   = 16;
    localparam int directedCount = 20;   // upper bound of the directed accesses
    localparam int fillCount     = memPkg::ramDepth;
    localparam int randCount     = 400;
    localparam int cycleLimit    = resetCycles + directedCount + fillCount + randCount + 100;

    logic                          clk;
    logic                          rstN;
    logic                          we;
    logic                          re;
    logic                          stSrc;
    logic                          ldSrc;
    logic [memPkg::addrWidth-1:0]  a;
    logic [memPkg::dataWidth-1:0]  wd;
    logic [memPkg::dataWidth-1:0]  rd;
    logic                          rdValid;
    logic                          hit;

    // reference state
    logic [memPkg::dataWidth-1:0]  refMem   [memPkg::ramDepth];
    logic                          refValid [2**memPkg::setWidth];
    logic [memPkg::tagWidth-1:0]   refTag   [2**memPkg::setWidth];
    logic [memPkg::dataWidth:0]    expQ [$];   // {hit, rd} per load in issue order
    int                            dueQ [$];   // cycle in which each load response is due

    integer seed;
    int     cycleCount;

    tbClock uClock (
        .clk  (clk),
        .rstN (rstN)
    );

    dataMemory u_dut (
        .clk     (clk),
        .rstN    (rstN),
        .we      (we),
        .re      (re),
        .stSrc   (stSrc),
        .ldSrc   (ldSrc),
        .a       (a),
        .wd      (wd),
        .rd      (rd),
        .rdValid (rdValid),
        .hit     (hit)
    );

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // store wins when both strobes are high
    function automatic memPkg::accessKind decodeKind(input logic weIn, input logic reIn,
                                                     input logic stIn, input logic ldIn);
        if (weIn) begin
            return stIn ? memPkg::storeByte : memPkg::storeWord;
        end else if (reIn) begin
            return ldIn ? memPkg::loadByte : memPkg::loadWord;
        end
        return memPkg::idle;
    endfunction

    // expected {hit, rd} of a load against the model state before the access
    function automatic logic [memPkg::dataWidth:0] expectedLoad(input logic byteLoad,
                                                                input logic [9:0] addr);
        logic [2:0]  set;
        logic [4:0]  tag;
        logic [31:0] word;
        logic        isHit;
        set   = addr[4:2];
        tag   = addr[9:5];
        word  = refMem[addr[9:2]];   // RAM always holds the latest data under write-through
        isHit = refValid[set] && (refTag[set] == tag);
        if (byteLoad) begin
            word = {24'h0, word[8*addr[1:0] +: 8]};
        end
        return {isHit, word};
    endfunction

    task automatic updateModel(input memPkg::accessKind kind, input logic [9:0] addr,
                               input logic [31:0] data);
        case (kind)
            memPkg::storeWord: begin
                refMem[addr[9:2]] = data;
                refValid[addr[4:2]] = 1'b1;   // word store allocates
                refTag[addr[4:2]]   = addr[9:5];
            end
            memPkg::storeByte: begin
                refMem[addr[9:2]][8*addr[1:0] +: 8] = data[7:0];   // no allocate
            end
            memPkg::loadWord, memPkg::loadByte: begin
                refValid[addr[4:2]] = 1'b1;   // a miss allocates and a hit changes nothing
                refTag[addr[4:2]]   = addr[9:5];
            end
            default: ;
        endcase
    endtask

    // drives one access 1 ns after the edge
    task automatic issue(input logic weIn, input logic reIn, input logic stIn,
                         input logic ldIn, input logic [9:0] addr, input logic [31:0] data);
        memPkg::accessKind kind;
        kind = decodeKind(weIn, reIn, stIn, ldIn);
        if (kind == memPkg::loadWord || kind == memPkg::loadByte) begin
            expQ.push_back(expectedLoad(kind == memPkg::loadByte, addr));
            dueQ.push_back(cycleCount + 1);   // sampled at the next edge, answered right after
        end
        updateModel(kind, addr, data);
        we    = weIn;
        re    = reIn;
        stSrc = stIn;
        ldSrc = ldIn;
        a     = addr;
        wd    = data;
        @(posedge clk);
        #1;
    endtask

    // responses are stable around the falling edge
    always @(negedge clk) begin
        if (rstN && rdValid === 1'b1) begin
            if (expQ.size() == 0) begin
                $display("unexpected load response at %0t ns with no load outstanding", $time);
                $display("TB FAILED");
                $fatal(1);
            end else begin
                logic [memPkg::dataWidth:0] exp;
                int                         due;
                exp = expQ.pop_front();
                due = dueQ.pop_front();
                checkValue(cycleCount, due, "load response cycle");
                checkValue(rd, exp[31:0], "load data");
                checkValue({31'h0, hit}, {31'h0, exp[32]}, "hit flag");
            end
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, the run never reached its end", cycleCount);
        $display("TB FAILED");
        $fatal(1);
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] data;
        logic [9:0]  addr;
        seed  = 32'he4bf3c1e;
        we    = 1'b0;
        re    = 1'b0;
        stSrc = 1'b0;
        ldSrc = 1'b0;
        a     = '0;
        wd    = '0;
        for (int s = 0; s < 2**memPkg::setWidth; s++) begin
            refValid[s] = 1'b0;
            refTag[s]   = '0;
        end
        wait (rstN === 1'b1);
        @(posedge clk);
        #1;
        checkValue({30'h0, rdValid, hit}, 32'h0, "outputs after reset");

        // word store allocates the line for the following load
        issue(1, 0, 0, 0, 10'h040, 32'h1234_5678);
        issue(0, 1, 0, 0, 10'h040, 32'h0);
        // byte merge into a cached line
        issue(1, 0, 1, 0, 10'h042, 32'h0000_00a5);
        issue(0, 1, 0, 0, 10'h040, 32'h0);
        issue(0, 1, 0, 1, 10'h042, 32'h0);
        // other tag in the same set evicts the line before a miss and a forwarded hit
        issue(1, 0, 0, 0, 10'h140, 32'hcafe_f00d);
        issue(0, 1, 0, 0, 10'h040, 32'h0);
        issue(0, 1, 0, 0, 10'h040, 32'h0);
        // byte store miss goes to RAM only
        issue(1, 0, 0, 0, 10'h2a4, 32'h0bad_beef);
        issue(1, 0, 0, 0, 10'h0a4, 32'h7777_1111);
        issue(1, 0, 1, 0, 10'h2a5, 32'h0000_003c);
        issue(0, 1, 0, 0, 10'h2a4, 32'h0);
        // both strobes give only the store and no response
        issue(1, 1, 0, 0, 10'h318, 32'h5a5a_0f0f);
        issue(0, 1, 0, 0, 10'h318, 32'h0);

        // fill pattern depends on the whole word index
        for (int i = 0; i < fillCount; i++) begin
            addr = 10'(i << 2);
            data = {8'(i), ~8'(i), 8'(i) ^ 8'h3c, 8'(i) + 8'h5b};
            issue(1, 0, 0, 0, addr, data);
        end

        for (int n = 0; n < randCount; n++) begin
            rnd  = $random(seed);
            data = $random(seed);
            addr = rnd[9:0];
            if (rnd[31]) begin
                addr[9:7] = 3'b000;   // fewer tags give more hits
            end
            // bit 11 picks store or load and bit 12 adds a read strobe to some stores
            issue(rnd[11], !rnd[11] || rnd[12], rnd[10], rnd[10], addr, data);
        end

        issue(0, 0, 0, 0, 10'h0, 32'h0);
        repeat (3) @(posedge clk);
        if (expQ.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("%0d load responses never arrived", expQ.size());
            $display("TB FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
